//--- filelist.f
mipsPkg.sv
instFetch.sv
fetchQueue.sv
instDecode.sv
registerFile.sv
executeStage.sv
mipsCore.sv
tbMipsCore.sv

//--- run.sh
#!/bin/sh
# Build and run the MIPS core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tbMipsCore \
    --Mdir objDir -o simMipsCore
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./objDir/simMipsCore > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    exit 1
fi
exit 0

//--- tbMipsCore.sv
`timescale 1ns/1ps

module tbMipsCore;
    import mipsPkg::*;

    localparam int programSize = 400;
    localparam int tableSize   = 512;
    localparam int runTimeout  = 20000; // Cycles after reset

    logic      clock;
    logic      arstN;
    logic      instAck;
    word_t     instData;
    logic      dataAck;
    logic      instRead;
    wordAddr_t instAddress;
    logic      dataWrite;
    wordAddr_t dataAddress;
    word_t     dataOut;

    integer    seed;
    word_t     progMem [programSize];
    wordAddr_t expAddr [programSize];
    word_t     expData [programSize];
    int        expIdx [programSize];     // Program index of each store
    int        expCount;
    int        instDelayTab [tableSize];
    int        dataDelayTab [tableSize];
    funct_t    rFuncts [8];
    opcode_t   iOpcodes [6];

    int        errorCount = 0;
    int        fetchCount = 0;
    int        storeCount = 0;
    int        instServed = 0;
    int        instWait   = 0;
    int        dataServed = 0;
    int        dataWait   = 0;
    int        cycles;
    wordAddr_t nextFetchAddr = resetVector;
    logic      prevInstRead  = 1'b0;
    logic      prevInstAck   = 1'b0;
    wordAddr_t prevInstAddr;
    logic      prevDataWrite = 1'b0;
    logic      prevDataAck   = 1'b0;
    wordAddr_t prevDataAddr;
    word_t     prevDataOut;

    mipsCore mipsCore_i (
        .clock       (clock),
        .arstN       (arstN),
        .instAck     (instAck),
        .instData    (instData),
        .dataAck     (dataAck),
        .instRead    (instRead),
        .instAddress (instAddress),
        .dataWrite   (dataWrite),
        .dataAddress (dataAddress),
        .dataOut     (dataOut)
    );

    function automatic int randBelow(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic word_t fetchWord(input wordAddr_t addr);
        wordAddr_t offset;
        offset = addr - resetVector;
        if (offset < programSize) return progMem[offset];
        return '0; // Past the program end reads as no-ops
    endfunction

    task automatic buildProgram;
        int          kind;
        regIdx_t     rs;
        regIdx_t     rt;
        regIdx_t     rd;
        logic [15:0] imm;
        rFuncts  = '{fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu};
        iOpcodes = '{opAddiu, opSlti, opAndi, opOri, opXori, opLui};
        for (int i = 0; i < programSize; i++) begin
            kind = randBelow(50);
            rs   = regIdx_t'(randBelow(8)); // Only r0..r7 for dense dependences
            rt   = regIdx_t'(randBelow(8));
            rd   = regIdx_t'(randBelow(8));
            imm  = 16'(randBelow(65536));
            if (kind < 10) begin
                rs = regIdx_t'(randBelow(4));
                progMem[i] = {opSw, rs, rt, 16'(randBelow(16) * 4)};
            end else if (kind < 13) begin
                case (randBelow(4))
                    0:       progMem[i] = {6'h08, rs, rt, imm}; // ADDI
                    1:       progMem[i] = {6'h23, rs, rt, imm}; // LW
                    2:       progMem[i] = {6'h04, rs, rt, imm}; // BEQ
                    default: progMem[i] = {opSpecial, rs, rt, rd, 5'd0, 6'h20}; // ADD
                endcase
            end else if (kind % 2 == 1) begin
                progMem[i] = {opSpecial, rs, rt, rd, 5'd0, rFuncts[randBelow(8)]};
            end else begin
                progMem[i] = {iOpcodes[randBelow(6)], rs, rt, imm};
            end
        end
    endtask

    // In-order ISA model that lists every expected store
    task automatic runModel;
        word_t   regs [32];
        word_t   a;
        word_t   b;
        word_t   sext;
        word_t   zext;
        word_t   result;
        logic    writes;
        regIdx_t dest;
        for (int r = 0; r < 32; r++) regs[r] = '0;
        expCount = 0;
        for (int i = 0; i < programSize; i++) begin
            a      = regs[progMem[i][25:21]];
            b      = regs[progMem[i][20:16]];
            sext   = {{16{progMem[i][15]}}, progMem[i][15:0]};
            zext   = {16'h0000, progMem[i][15:0]};
            dest   = progMem[i][20:16];
            writes = 1'b1;
            result = '0;
            case (opcode_t'(progMem[i][31:26]))
                opSpecial: begin
                    dest = progMem[i][15:11];
                    case (funct_t'(progMem[i][5:0]))
                        fnAddu:  result = a + b;
                        fnSubu:  result = a - b;
                        fnAnd:   result = a & b;
                        fnOr:    result = a | b;
                        fnXor:   result = a ^ b;
                        fnNor:   result = ~(a | b);
                        fnSlt:   result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        fnSltu:  result = (a < b) ? 32'd1 : 32'd0;
                        default: writes = 1'b0;
                    endcase
                end
                opAddiu: result = a + sext;
                opSlti:  result = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
                opAndi:  result = a & zext;
                opOri:   result = a | zext;
                opXori:  result = a ^ zext;
                opLui:   result = {progMem[i][15:0], 16'h0000};
                opSw: begin
                    writes = 1'b0;
                    result = a + sext;
                    expAddr[expCount] = result[31:2];
                    expData[expCount] = b;
                    expIdx[expCount]  = i;
                    expCount++;
                end
                default: writes = 1'b0;
            endcase
            if (writes && dest != 5'd0) regs[dest] = result;
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Instruction memory, four-phase
    always @(posedge clock) begin
        if (!arstN) begin
            instAck <= 1'b0;
            instWait = 0;
        end else if (instAck) begin
            if (!instRead) instAck <= 1'b0;
        end else if (instRead) begin
            if (instWait >= instDelayTab[instServed % tableSize]) begin
                instAck  <= 1'b1;
                instData <= fetchWord(instAddress);
                instServed++;
                instWait = 0;
            end else begin
                instWait++;
            end
        end
    end

    // Data memory, one-cycle ack
    always @(posedge clock) begin
        if (!arstN) begin
            dataAck <= 1'b0;
            dataWait = 0;
        end else if (dataAck) begin
            dataAck <= 1'b0;
        end else if (dataWrite) begin
            if (dataWait >= dataDelayTab[dataServed % tableSize]) begin
                dataAck <= 1'b1;
                dataServed++;
                dataWait = 0;
            end else begin
                dataWait++;
            end
        end
    end

    always @(posedge clock) begin
        if (!arstN) begin
            if (instRead || dataWrite) begin
                $display("[ERROR] %0t: instRead or dataWrite high during reset", $time);
                errorCount++;
            end
            prevInstRead  = 1'b0;
            prevInstAck   = 1'b0;
            prevDataWrite = 1'b0;
            prevDataAck   = 1'b0;
        end else begin
            if (prevInstRead && !prevInstAck) begin
                if (!instRead || instAddress != prevInstAddr) begin
                    $display("[ERROR] %0t: instRead dropped or address moved before instAck",
                             $time);
                    errorCount++;
                end
            end
            if (instRead && !prevInstRead) begin
                if (instAck) begin
                    $display("[ERROR] %0t: instRead raised while instAck high", $time);
                    errorCount++;
                end
                if (instAddress != nextFetchAddr) begin
                    $display("[ERROR] %0t: fetch address %h, expected %h", $time,
                             instAddress, nextFetchAddr);
                    errorCount++;
                end
            end
            if (instRead && instAck) begin // Capture edge
                fetchCount++;
                nextFetchAddr = nextFetchAddr + 30'd1;
            end
            if (prevDataWrite && !prevDataAck) begin
                if (!dataWrite || dataAddress != prevDataAddr || dataOut != prevDataOut) begin
                    $display("[ERROR] %0t: store changed or dropped before dataAck", $time);
                    errorCount++;
                end
            end
            if (prevDataWrite && prevDataAck && dataWrite) begin
                $display("[ERROR] %0t: dataWrite still high after dataAck", $time);
                errorCount++;
            end
            // Store in execute means everything before it has completed
            if (dataWrite && storeCount < expCount) begin
                if (fetchCount - expIdx[storeCount] > queueDepth + 1) begin
                    $display("[ERROR] %0t: fetch %0d words ahead of execute", $time,
                             fetchCount - expIdx[storeCount]);
                    errorCount++;
                end
            end
            if (dataWrite && dataAck) begin
                if (storeCount >= expCount) begin
                    $display("[ERROR] %0t: unexpected extra store to %h", $time, dataAddress);
                    errorCount++;
                end else begin
                    if (dataAddress != expAddr[storeCount] || dataOut != expData[storeCount]) begin
                        $display("[ERROR] %0t: store %0d got %h <- %h, expected %h <- %h",
                                 $time, storeCount, dataAddress, dataOut,
                                 expAddr[storeCount], expData[storeCount]);
                        errorCount++;
                    end
                    storeCount++;
                end
            end
            prevInstRead  = instRead;
            prevInstAck   = instAck;
            prevInstAddr  = instAddress;
            prevDataWrite = dataWrite;
            prevDataAck   = dataAck;
            prevDataAddr  = dataAddress;
            prevDataOut   = dataOut;
        end
    end

    initial begin
        seed     = 48;
        arstN    = 1'b0;
        instAck  = 1'b0;
        instData = '0;
        dataAck  = 1'b0;
        buildProgram();
        runModel();
        for (int i = 0; i < tableSize; i++) begin
            instDelayTab[i] = randBelow(4);
            dataDelayTab[i] = randBelow(6);
        end
        repeat (16) @(posedge clock);
        arstN <= 1'b1;
        // Fetching this far past the end means every program word has completed
        cycles = 0;
        while ((fetchCount < programSize + queueDepth + 2 || storeCount < expCount)
               && cycles < runTimeout) begin
            @(posedge clock);
            cycles++;
        end
        if (fetchCount < programSize + queueDepth + 2 || storeCount < expCount) begin
            $display("Timeout: the core did not finish the program in %0d cycles", runTimeout);
            errorCount++;
        end
        if (storeCount != expCount) begin
            $display("[ERROR] %0t: %0d stores seen, %0d expected", $time, storeCount, expCount);
            errorCount++;
        end
        $display("Stores %0d of %0d, words fetched %0d, errors %0d",
                 storeCount, expCount, fetchCount, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- mipsCore.sv
`timescale 1ns/1ps

module mipsCore (
    input  logic               clock,
    input  logic               arstN,
    input  logic               instAck,
    input  mipsPkg::word_t     instData,
    input  logic               dataAck,
    output logic               instRead,
    output mipsPkg::wordAddr_t instAddress,
    output logic               dataWrite,
    output mipsPkg::wordAddr_t dataAddress,
    output mipsPkg::word_t     dataOut
);
    import mipsPkg::*;

    logic       pushValid;
    word_t      pushData;
    logic       popValid;
    word_t      popData;
    logic       popReady;
    logic [2:0] queueCount;

    instFetch instFetch_i (
        .clock       (clock),
        .arstN       (arstN),
        .queueCount  (queueCount),
        .instAck     (instAck),
        .instData    (instData),
        .instRead    (instRead),
        .instAddress (instAddress),
        .pushValid   (pushValid),
        .pushData    (pushData)
    );

    fetchQueue fetchQueue_i (
        .clock     (clock),
        .arstN     (arstN),
        .pushValid (pushValid),
        .pushData  (pushData),
        .popReady  (popReady),
        .popValid  (popValid),
        .popData   (popData),
        .count     (queueCount)
    );

    executeStage executeStage_i (
        .clock       (clock),
        .arstN       (arstN),
        .popValid    (popValid),
        .popData     (popData),
        .popReady    (popReady),
        .dataAck     (dataAck),
        .dataWrite   (dataWrite),
        .dataAddress (dataAddress),
        .dataOut     (dataOut)
    );

endmodule

//--- executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic               clock,
    input  logic               arstN,
    input  logic               popValid,
    input  mipsPkg::word_t     popData,
    output logic               popReady,
    input  logic               dataAck,
    output logic               dataWrite,
    output mipsPkg::wordAddr_t dataAddress,
    output mipsPkg::word_t     dataOut
);
    import mipsPkg::*;

    // Decode side
    aluOp_t  decAluOp;
    logic    decUseImm;
    logic    decZeroExtend;
    logic    decWritesReg;
    logic    decIsStore;
    regIdx_t decDest;
    regIdx_t rsIdx;
    regIdx_t rtIdx;
    word_t   rfA;
    word_t   rfB;
    word_t   srcA;
    word_t   srcB;
    word_t   decImm;
    logic    fwdHit;

    // Execute side
    logic    exValid;
    logic    exWritesReg;
    logic    exIsStore;
    aluOp_t  exAluOp;
    word_t   exOpA;
    word_t   exRegB;
    word_t   exImm;
    logic    exUseImm;
    regIdx_t exDest;
    word_t   aluB;
    word_t   aluResult;
    logic    storeGap;

    instDecode instDecode_i (
        .instr      (popData),
        .aluOp      (decAluOp),
        .useImm     (decUseImm),
        .zeroExtend (decZeroExtend),
        .writesReg  (decWritesReg),
        .isStore    (decIsStore),
        .destReg    (decDest)
    );

    registerFile registerFile_i (
        .clock       (clock),
        .arstN       (arstN),
        .readIdxA    (rsIdx),
        .readIdxB    (rtIdx),
        .readA       (rfA),
        .readB       (rfB),
        .writeEnable (exValid && exWritesReg),
        .writeIdx    (exDest),
        .writeData   (aluResult)
    );

    assign rsIdx  = popData[25:21];
    assign rtIdx  = popData[20:16];
    assign decImm = decZeroExtend ? {16'h0000, popData[15:0]}
                                  : {{16{popData[15]}}, popData[15:0]};

    // Result being written this cycle bypasses the register file
    assign fwdHit = exValid && exWritesReg && (exDest != 5'd0);
    assign srcA   = (fwdHit && exDest == rsIdx) ? aluResult : rfA;
    assign srcB   = (fwdHit && exDest == rtIdx) ? aluResult : rfB;

    // Store holds execute until acked; one idle cycle between stores
    assign dataWrite = exValid && exIsStore && !storeGap;
    assign popReady  = !(exValid && exIsStore) || (dataWrite && dataAck);

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            exValid     <= 1'b0;
            exWritesReg <= 1'b0;
            exIsStore   <= 1'b0;
            exAluOp     <= aluAdd;
            storeGap    <= 1'b0;
        end else begin
            storeGap <= dataWrite && dataAck;
            if (popReady) begin
                exValid     <= popValid;
                exWritesReg <= popValid && decWritesReg;
                exIsStore   <= popValid && decIsStore;
                exAluOp     <= decAluOp;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (popReady && popValid) begin
            exOpA    <= srcA;
            exRegB   <= srcB; // Also the store data
            exImm    <= decImm;
            exUseImm <= decUseImm;
            exDest   <= decDest;
        end
    end

    assign aluB = exUseImm ? exImm : exRegB;

    always_comb begin
        unique case (exAluOp)
            aluAdd:  aluResult = exOpA + aluB;
            aluSub:  aluResult = exOpA - aluB;
            aluAnd:  aluResult = exOpA & aluB;
            aluOr:   aluResult = exOpA | aluB;
            aluXor:  aluResult = exOpA ^ aluB;
            aluNor:  aluResult = ~(exOpA | aluB);
            aluSlt:  aluResult = {31'd0, $signed(exOpA) < $signed(aluB)};
            aluSltu: aluResult = {31'd0, exOpA < aluB};
            aluLui:  aluResult = {aluB[15:0], 16'h0000};
            default: aluResult = '0;
        endcase
    end

    assign dataAddress = aluResult[31:2]; // Word address of the store
    assign dataOut     = exRegB;

endmodule

//--- registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic             clock,
    input  logic             arstN,
    input  mipsPkg::regIdx_t readIdxA,
    input  mipsPkg::regIdx_t readIdxB,
    output mipsPkg::word_t   readA,
    output mipsPkg::word_t   readB,
    input  logic             writeEnable,
    input  mipsPkg::regIdx_t writeIdx,
    input  mipsPkg::word_t   writeData
);
    import mipsPkg::*;

    word_t regs [32];

    // $zero is never written and keeps its reset value
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeIdx != 5'd0) begin
            regs[writeIdx] <= writeData;
        end
    end

    assign readA = regs[readIdxA];
    assign readB = regs[readIdxB];

endmodule

//--- instDecode.sv
`timescale 1ns/1ps

module instDecode (
    input  mipsPkg::word_t   instr,
    output mipsPkg::aluOp_t  aluOp,
    output logic             useImm,
    output logic             zeroExtend,
    output logic             writesReg,
    output logic             isStore,
    output mipsPkg::regIdx_t destReg
);
    import mipsPkg::*;

    opcode_t opcode;
    funct_t  funct;
    regIdx_t rt;
    regIdx_t rd;

    assign opcode = instr[31:26];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign funct  = instr[5:0];

    always_comb begin
        // Unknown encodings fall through as a no-op
        aluOp      = aluAdd;
        useImm     = 1'b0;
        zeroExtend = 1'b0;
        writesReg  = 1'b0;
        isStore    = 1'b0;
        destReg    = rt;
        unique case (opcode)
            opSpecial: begin
                destReg   = rd;
                writesReg = 1'b1;
                unique case (funct)
                    fnAddu:  aluOp = aluAdd;
                    fnSubu:  aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnXor:   aluOp = aluXor;
                    fnNor:   aluOp = aluNor;
                    fnSlt:   aluOp = aluSlt;
                    fnSltu:  aluOp = aluSltu;
                    default: writesReg = 1'b0;
                endcase
            end
            opAddiu: {aluOp, useImm, writesReg} = {aluAdd, 2'b11};
            opSlti:  {aluOp, useImm, writesReg} = {aluSlt, 2'b11};
            opAndi:  {aluOp, useImm, zeroExtend, writesReg} = {aluAnd, 3'b111};
            opOri:   {aluOp, useImm, zeroExtend, writesReg} = {aluOr, 3'b111};
            opXori:  {aluOp, useImm, zeroExtend, writesReg} = {aluXor, 3'b111};
            opLui:   {aluOp, useImm, writesReg} = {aluLui, 2'b11};
            opSw:    {aluOp, useImm, isStore} = {aluAdd, 2'b11}; // Base plus offset
            default: ;
        endcase
    end

endmodule

//--- fetchQueue.sv
`timescale 1ns/1ps

module fetchQueue (
    input  logic           clock,
    input  logic           arstN,
    input  logic           pushValid,
    input  mipsPkg::word_t pushData,
    input  logic           popReady,
    output logic           popValid,
    output mipsPkg::word_t popData,
    output logic [2:0]     count
);
    import mipsPkg::*;

    word_t mem [queueDepth];
    logic [$clog2(queueDepth)-1:0] wrPtr;
    logic [$clog2(queueDepth)-1:0] rdPtr;
    logic doPush;
    logic doPop;

    assign popValid = (count != 3'd0);
    assign popData  = mem[rdPtr];
    assign doPop    = popValid && popReady;
    assign doPush   = pushValid && ((count < queueDepth) || doPop);

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= 3'd0;
        end else begin
            if (doPush) wrPtr <= wrPtr + 1'b1; // Wraps at the depth
            if (doPop) rdPtr <= rdPtr + 1'b1;
            unique case ({doPush, doPop})
                2'b10:   count <= count + 3'd1;
                2'b01:   count <= count - 3'd1;
                default: count <= count; // Both or neither
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (doPush) mem[wrPtr] <= pushData;
    end

endmodule

//--- instFetch.sv
`timescale 1ns/1ps

module instFetch (
    input  logic               clock,
    input  logic               arstN,
    input  logic [2:0]         queueCount,
    input  logic               instAck,
    input  mipsPkg::word_t     instData,
    output logic               instRead,
    output mipsPkg::wordAddr_t instAddress,
    output logic               pushValid,
    output mipsPkg::word_t     pushData
);
    import mipsPkg::*;

    fetchState_t state;
    wordAddr_t   pc;
    logic [3:0]  promised;
    logic        hasSpace;

    // A word captured but not yet pushed already owns an entry
    assign promised = {1'b0, queueCount} + {3'b000, pushValid};
    assign hasSpace = promised < queueDepth;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            state     <= fetchIdle;
            pc        <= resetVector;
            pushValid <= 1'b0;
        end else begin
            pushValid <= 1'b0;
            unique case (state)
                fetchIdle: begin
                    if (hasSpace) state <= fetchRequest;
                end
                fetchRequest: begin
                    if (instAck) begin // Word is valid now
                        state     <= fetchRelease;
                        pushValid <= 1'b1;
                        pc        <= pc + 30'd1;
                    end
                end
                fetchRelease: begin
                    if (!instAck) state <= fetchIdle; // Memory finished its phase
                end
                default: state <= fetchIdle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == fetchRequest && instAck) pushData <= instData;
    end

    assign instRead    = (state == fetchRequest);
    assign instAddress = pc; // Held until the capture edge

endmodule

//--- mipsPkg.sv
package mipsPkg;

    typedef logic [31:0] word_t;     // Data word or instruction
    typedef logic [29:0] wordAddr_t; // Byte offset bits removed
    typedef logic [4:0]  regIdx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSltu,
        aluLui
    } aluOp_t;

    typedef enum logic [1:0] {
        fetchIdle,
        fetchRequest,
        fetchRelease
    } fetchState_t;

    // Boot address 0xBFC00000 as a word address
    localparam wordAddr_t resetVector = 30'h2FF0_0000;

    localparam int queueDepth = 4;

    // Primary opcodes
    localparam opcode_t opSpecial = 6'h00;
    localparam opcode_t opAddiu   = 6'h09;
    localparam opcode_t opSlti    = 6'h0A;
    localparam opcode_t opAndi    = 6'h0C;
    localparam opcode_t opOri     = 6'h0D;
    localparam opcode_t opXori    = 6'h0E;
    localparam opcode_t opLui     = 6'h0F;
    localparam opcode_t opSw      = 6'h2B;

    // Function codes under opSpecial
    localparam funct_t fnAddu = 6'h21;
    localparam funct_t fnSubu = 6'h23;
    localparam funct_t fnAnd  = 6'h24;
    localparam funct_t fnOr   = 6'h25;
    localparam funct_t fnXor  = 6'h26;
    localparam funct_t fnNor  = 6'h27;
    localparam funct_t fnSlt  = 6'h2A;
    localparam funct_t fnSltu = 6'h2B;

endpackage
